/* Makefile */
TOP  := vae_inference_tb
BIN  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' vae_inference_top.f)

.PHONY: all run clean

all: $(BIN)

$(BIN): vae_inference_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f vae_inference_top.f

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Test passed$$'

clean:
	rm -rf obj_dir

/* bench/vae_inference_properties.sv */
// Concurrent checks on the VAE inference top, attached by bind
`timescale 1ns/1ps
`default_nettype none

module vae_inference_properties (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    out_valid,
    input vae_net_pkg::pixel_out_t out_pixel,
    input logic                    push,
    input logic                    empty
);

    function automatic vae_net_pkg::pixel_idx_t next_index(input vae_net_pkg::pixel_idx_t idx);
        vae_net_pkg::pixel_idx_t nxt;
        if (idx == vae_net_pkg::pixel_idx_t'(vae_net_pkg::N_PIX - 1)) begin
            nxt = '0;
        end else begin
            nxt = idx + 1'b1;
        end
        return nxt;
    endfunction

    a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high while reset is asserted");

    a_index_range: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> (out_pixel.index < vae_net_pkg::pixel_idx_t'(vae_net_pkg::N_PIX)))
        else $error("out_pixel.index out of range");

    // Back-to-back pixels walk 0..8 and wrap
    a_index_step: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && $past(out_valid)) |-> (out_pixel.index == next_index($past(out_pixel.index))))
        else $error("out_pixel.index did not advance by one");

    // A push into an empty queue shows up one cycle later
    a_empty_falls: assert property (@(posedge clk) disable iff (!arst_n)
        (empty && push) |=> !empty)
        else $error("latent queue still empty after a push");

endmodule

bind vae_inference_top vae_inference_properties props (
    .clk       (clk),
    .arst_n    (arst_n),
    .out_valid (out_valid),
    .out_pixel (out_pixel),
    .push      (lat_push),
    .empty     (lat_empty)
);

`default_nettype wire

/* bench/vae_inference_tb.sv */
// Testbench for the VAE inference top, LFSR stimulus against a reference model
`timescale 1ns/1ps
`default_nettype none

module vae_inference_tb;

    localparam int N_PIX          = vae_net_pkg::N_PIX;
    localparam int N_LAT          = vae_net_pkg::N_LAT;
    localparam int N_DEFAULT_PAT  = 8;
    localparam int N_RANDOM_PAT   = 24;
    localparam int N_NEG_PAT      = 6;
    localparam int N_OOR_PAT      = 8;
    localparam int N_BURST_PAT    = 12;
    localparam int TOTAL_PAT      = N_DEFAULT_PAT + N_RANDOM_PAT + 2 * N_NEG_PAT
                                    + N_OOR_PAT + N_BURST_PAT;
    // One full load of both banks
    localparam int LOAD_WRITES    = N_LAT * (N_PIX + 1) + N_PIX * (N_LAT + 1);
    localparam int OOR_WRITES     = 28;
    localparam int RESET_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = 12 * TOTAL_PAT + 4 * (LOAD_WRITES + 1) + OOR_WRITES + 1
                                    + RESET_CYCLES + 6 * 16;

    // Reset values, 0.125 and 0.1 truncated to Q16.16
    localparam logic [31:0] RESET_WEIGHT = 32'h0000_2000;
    localparam logic [31:0] RESET_BIAS   = 32'h0000_1999;

    localparam int KIND_SIGNED = 0;
    localparam int KIND_NEG    = 1;
    localparam int KIND_POS    = 2;

    logic                    clk;
    logic                    arst_n;
    logic                    in_valid;
    logic [N_PIX-1:0]        in_pixels;
    logic                    in_full;
    logic                    wt_wr;
    vae_net_pkg::wt_write_t  wt;
    logic                    out_valid;
    vae_net_pkg::pixel_out_t out_pixel;

    // Model copy of every weight and bias
    fixed_point_pkg::q16_t ref_enc_w [N_LAT][N_PIX];
    fixed_point_pkg::q16_t ref_enc_b [N_LAT];
    fixed_point_pkg::q16_t ref_dec_w [N_PIX][N_LAT];
    fixed_point_pkg::q16_t ref_dec_b [N_PIX];

    vae_net_pkg::pixel_out_t exp_q [$];

    logic [31:0] lfsr_state;
    int          accepted;
    int          dropped;
    int          checked;
    int          zero_seen;
    int          neg_base;
    logic        saw_full;
    logic        gap_check;
    logic        seen_valid;

    vae_inference_top dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_pixels (in_pixels),
        .in_full   (in_full),
        .wt_wr     (wt_wr),
        .wt        (wt),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        stop_on_error("Timeout, the expected results did not all arrive in time");
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic fixed_point_pkg::q16_t random_weight(input int kind);
        logic [31:0]           r;
        fixed_point_pkg::q16_t w;
        case (kind)
            KIND_NEG: begin
                // Between -2.0 and -3.0
                r = rand_bits(16);
                w = -(32'h0002_0000 + r);
            end
            KIND_POS: begin
                r = rand_bits(17);
                w = r;
            end
            default: begin
                r = rand_bits(18);
                w = {{14{r[17]}}, r[17:0]};
            end
        endcase
        return w;
    endfunction

    function automatic fixed_point_pkg::q16_t fixed_mul(input fixed_point_pkg::q16_t a,
                                                        input fixed_point_pkg::q16_t b);
        longint prod;
        prod = longint'(a) * longint'(b);
        prod = prod >>> 16;
        return prod[31:0];
    endfunction

    // Expected decoder output p for one input pattern
    function automatic fixed_point_pkg::q16_t model_pixel(input logic [N_PIX-1:0] pixels,
                                                          input int p);
        fixed_point_pkg::q16_t mean [N_LAT];
        fixed_point_pkg::q16_t acc;
        for (int l = 0; l < N_LAT; l++) begin
            acc = ref_enc_b[l];
            for (int i = 0; i < N_PIX; i++) begin
                if (pixels[i]) begin
                    acc = acc + ref_enc_w[l][i];
                end
            end
            mean[l] = acc[31] ? '0 : acc;
        end
        acc = fixed_mul(mean[0], ref_dec_w[p][0]) + fixed_mul(mean[1], ref_dec_w[p][1])
              + ref_dec_b[p];
        return acc[31] ? '0 : acc;
    endfunction

    function automatic logic [6:0] enc_addr(input int latent, input int tap);
        return {1'b0, 1'b0, latent[0], tap[3:0]};
    endfunction

    function automatic logic [6:0] dec_addr(input int out_idx, input int tap);
        return {1'b1, out_idx[3:0], tap[1:0]};
    endfunction

    task automatic reset_model();
        for (int l = 0; l < N_LAT; l++) begin
            for (int p = 0; p < N_PIX; p++) begin
                ref_enc_w[l][p] = RESET_WEIGHT;
                ref_dec_w[p][l] = RESET_WEIGHT;
            end
            ref_enc_b[l] = RESET_BIAS;
        end
        for (int p = 0; p < N_PIX; p++) begin
            ref_dec_b[p] = RESET_BIAS;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #0.5;
        in_valid = 1'b0;
        wt_wr    = 1'b0;
    endtask

    // Out-of-range addresses leave the model untouched
    task automatic write_word(input logic [6:0] addr, input fixed_point_pkg::q16_t data);
        int idx;
        int tap;
        @(posedge clk);
        #0.5;
        in_valid = 1'b0;
        wt_wr    = 1'b1;
        wt       = {addr, data};
        if (addr[6] == 1'b0) begin
            idx = int'(addr[4]);
            tap = int'(addr[3:0]);
            if (tap < N_PIX) begin
                ref_enc_w[idx][tap] = data;
            end else if (tap == N_PIX) begin
                ref_enc_b[idx] = data;
            end
        end else begin
            idx = int'(addr[5:2]);
            tap = int'(addr[1:0]);
            if (idx < N_PIX && tap < N_LAT) begin
                ref_dec_w[idx][tap] = data;
            end else if (idx < N_PIX && tap == N_LAT) begin
                ref_dec_b[idx] = data;
            end
        end
    endtask

    task automatic load_banks(input int enc_kind, input int dec_kind);
        for (int l = 0; l < N_LAT; l++) begin
            for (int t = 0; t <= N_PIX; t++) begin
                write_word(enc_addr(l, t), random_weight(enc_kind));
            end
        end
        for (int o = 0; o < N_PIX; o++) begin
            for (int t = 0; t <= N_LAT; t++) begin
                write_word(dec_addr(o, t), random_weight(dec_kind));
            end
        end
        idle_cycle();
    endtask

    task automatic write_out_of_range();
        for (int l = 0; l < N_LAT; l++) begin
            for (int t = 10; t < 16; t++) begin
                write_word(enc_addr(l, t), rand_bits(32));
            end
        end
        for (int o = N_PIX; o < 16; o++) begin
            write_word(dec_addr(o, 0), rand_bits(32));
        end
        for (int o = 0; o < N_PIX; o++) begin
            write_word(dec_addr(o, 3), rand_bits(32));
        end
        idle_cycle();
    endtask

    task automatic send_pattern(input logic [N_PIX-1:0] pixels);
        vae_net_pkg::pixel_out_t entry;
        @(posedge clk);
        #0.5;
        wt_wr     = 1'b0;
        in_valid  = 1'b1;
        in_pixels = pixels;
        // in_full holds its value up to the strobing edge
        if (!in_full) begin
            for (int p = 0; p < N_PIX; p++) begin
                entry.index = vae_net_pkg::pixel_idx_t'(p);
                entry.value = model_pixel(pixels, p);
                exp_q.push_back(entry);
            end
            accepted++;
        end else begin
            dropped++;
        end
    endtask

    task automatic run_patterns(input int count, input logic gaps);
        logic [31:0] r;
        logic [31:0] gap;
        for (int i = 0; i < count; i++) begin
            r = rand_bits(N_PIX);
            send_pattern(r[N_PIX-1:0]);
            if (gaps) begin
                gap = rand_bits(2);
                repeat (gap) idle_cycle();
            end
        end
        idle_cycle();
    endtask

    task automatic wait_for_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    always @(negedge clk) begin : compare
        vae_net_pkg::pixel_out_t expected;
        if (arst_n && out_valid) begin
            assert (exp_q.size() != 0)
                else stop_on_error("out_valid pulsed while no result was pending");
            expected = exp_q.pop_front();
            assert (out_pixel.index == expected.index)
                else stop_on_error($sformatf("[FAIL] out_pixel.index: expected %h, got %h",
                                             expected.index, out_pixel.index));
            assert (out_pixel.value == expected.value)
                else stop_on_error($sformatf("[FAIL] out_pixel.value: expected %h, got %h",
                                             expected.value, out_pixel.value));
            checked++;
            if (out_pixel.value == '0) begin
                zero_seen++;
            end
        end
        if (gap_check && in_full) begin
            saw_full = 1'b1;
        end
        if (gap_check) begin
            if (out_valid) begin
                seen_valid = 1'b1;
            end else if (seen_valid) begin
                assert (exp_q.size() == 0)
                    else stop_on_error("out_valid dropped while results were still queued");
            end
        end
    end

    initial begin
        in_valid      = 1'b0;
        in_pixels     = '0;
        wt_wr         = 1'b0;
        wt            = '0;
        arst_n        = 1'b0;
        lfsr_state    = 32'h82a4ea18;
        accepted      = 0;
        dropped       = 0;
        checked       = 0;
        zero_seen     = 0;
        neg_base      = 0;
        saw_full      = 1'b0;
        gap_check     = 1'b0;
        seen_valid    = 1'b0;
        reset_model();

        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        @(posedge clk);
        #0.5;
        assert (!in_full)
            else stop_on_error($sformatf("[FAIL] in_full: expected %h, got %h",
                                         1'b0, in_full));
        assert (!out_valid)
            else stop_on_error($sformatf("[FAIL] out_valid: expected %h, got %h",
                                         1'b0, out_valid));

        // Reset weights
        run_patterns(N_DEFAULT_PAT, 1'b1);
        wait_for_drain();

        load_banks(KIND_SIGNED, KIND_SIGNED);
        run_patterns(N_RANDOM_PAT, 1'b1);
        wait_for_drain();

        // Both latent means clamp to zero
        zero_seen = 0;
        neg_base  = accepted;
        load_banks(KIND_NEG, KIND_NEG);
        run_patterns(N_NEG_PAT, 1'b1);
        wait_for_drain();
        // Positive means, decoder sums pulled below zero
        load_banks(KIND_POS, KIND_NEG);
        run_patterns(N_NEG_PAT, 1'b1);
        wait_for_drain();
        assert (zero_seen == (accepted - neg_base) * N_PIX)
            else stop_on_error("Negative weights did not drive every output to zero");

        load_banks(KIND_SIGNED, KIND_SIGNED);
        write_out_of_range();
        run_patterns(N_OOR_PAT, 1'b1);
        wait_for_drain();

        // Back-to-back strobes overrun the queue
        saw_full   = 1'b0;
        dropped    = 0;
        seen_valid = 1'b0;
        gap_check  = 1'b1;
        run_patterns(N_BURST_PAT, 1'b0);
        wait_for_drain();
        gap_check  = 1'b0;
        assert (saw_full)
            else stop_on_error("in_full never rose during the strobe burst");
        assert (dropped > 0)
            else stop_on_error("No pattern was dropped during the strobe burst");

        if (checked != accepted * N_PIX) begin
            stop_on_error("Number of checked pixels does not match the accepted patterns");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* src/fixed_point_pkg.sv */
// Q16.16 fixed-point type, constants and arithmetic helpers
`default_nettype none

package fixed_point_pkg;

    // Signed, 16 integer bits and 16 fraction bits
    typedef logic signed [31:0] q16_t;

    localparam int Q_FRAC_BITS = 16;

    localparam q16_t Q_ONE  = 32'h0001_0000;
    // 0.125
    localparam q16_t W_INIT = 32'h0000_2000;
    // 0.1, truncated
    localparam q16_t B_INIT = 32'h0000_1999;

    // Full-width product, rescaled and truncated back to 32 bits
    function automatic q16_t q_mul(input q16_t a, input q16_t b);
        logic signed [63:0] prod;
        prod = 64'(a) * 64'(b);
        prod = prod >>> Q_FRAC_BITS;
        return prod[31:0];
    endfunction

    function automatic q16_t q_relu(input q16_t x);
        q16_t res;
        if (x[31]) begin
            res = '0;
        end else begin
            res = x;
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* src/latent_fifo.sv */
// Latent vector queue, first-word-fall-through, between encoder and decoder
`timescale 1ns/1ps
`default_nettype none

module latent_fifo (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 push,
    input  vae_net_pkg::latent_t push_data,
    input  logic                 pop,
    output logic                 full,
    output logic                 empty,
    output vae_net_pkg::latent_t head
);

    localparam int DEPTH = vae_net_pkg::LAT_FIFO_DEPTH;

    vae_net_pkg::latent_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    assign full    = (count == ($clog2(DEPTH+1))'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves occupancy unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/vae_decoder.sv */
// VAE decoder, weight bank and sequencer emitting one reconstructed pixel per cycle
`timescale 1ns/1ps
`default_nettype none

module vae_decoder (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    empty,
    input  vae_net_pkg::latent_t    head,
    output logic                    pop,
    input  logic                    wt_wr,
    input  vae_net_pkg::wt_write_t  wt,
    output logic                    out_valid,
    output vae_net_pkg::pixel_out_t out_pixel
);

    fixed_point_pkg::q16_t dec_w [vae_net_pkg::N_PIX][vae_net_pkg::N_LAT];
    fixed_point_pkg::q16_t dec_b [vae_net_pkg::N_PIX];

    vae_net_pkg::latent_t   lat_q;
    vae_net_pkg::pixel_idx_t pix_cnt;
    logic                   busy;
    logic                   last_pix;

    logic                   dec_sel;
    logic                   bias_sel;

    fixed_point_pkg::q16_t  prod0;
    fixed_point_pkg::q16_t  prod1;
    fixed_point_pkg::q16_t  pix_sum;

    // Decoder-bank writes, output 0..8 and tap 0..2
    assign dec_sel  = wt_wr && (wt.addr.dec.bank == 1'b1)
                      && (wt.addr.dec.out_idx < 4'(vae_net_pkg::N_PIX))
                      && (wt.addr.dec.tap <= 2'(vae_net_pkg::DEC_BIAS_TAP));
    assign bias_sel = (wt.addr.dec.tap == 2'(vae_net_pkg::DEC_BIAS_TAP));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < vae_net_pkg::N_PIX; p++) begin
                for (int l = 0; l < vae_net_pkg::N_LAT; l++) begin
                    dec_w[p][l] <= fixed_point_pkg::W_INIT;
                end
                dec_b[p] <= fixed_point_pkg::B_INIT;
            end
        end else if (dec_sel) begin
            if (bias_sel) begin
                dec_b[wt.addr.dec.out_idx] <= wt.data;
            end else begin
                dec_w[wt.addr.dec.out_idx][wt.addr.dec.tap[0]] <= wt.data;
            end
        end
    end

    assign last_pix = busy && (pix_cnt == vae_net_pkg::pixel_idx_t'(vae_net_pkg::N_PIX - 1));

    // Take the next latent when idle or while finishing pixel 8
    assign pop = !empty && (!busy || last_pix);

    // One shared pair of multipliers for the current pixel
    assign prod0   = fixed_point_pkg::q_mul(lat_q.mean0, dec_w[pix_cnt][0]);
    assign prod1   = fixed_point_pkg::q_mul(lat_q.mean1, dec_w[pix_cnt][1]);
    assign pix_sum = prod0 + prod1 + dec_b[pix_cnt];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            pix_cnt   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= busy;
            if (pop) begin
                busy    <= 1'b1;
                pix_cnt <= '0;
            end else if (last_pix) begin
                busy <= 1'b0;
            end else if (busy) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            lat_q <= head;
        end
        if (busy) begin
            out_pixel.index <= pix_cnt;
            out_pixel.value <= fixed_point_pkg::q_relu(pix_sum);
        end
    end

endmodule

`default_nettype wire

/* src/vae_encoder.sv */
// VAE encoder, weight bank plus combinational latent means with ReLU
`timescale 1ns/1ps
`default_nettype none

module vae_encoder (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  logic [vae_net_pkg::N_PIX-1:0]     in_pixels,
    input  logic                              wt_wr,
    input  vae_net_pkg::wt_write_t            wt,
    output logic                              push,
    output vae_net_pkg::latent_t              latent
);

    fixed_point_pkg::q16_t enc_w [vae_net_pkg::N_LAT][vae_net_pkg::N_PIX];
    fixed_point_pkg::q16_t enc_b [vae_net_pkg::N_LAT];

    logic enc_sel;
    logic bias_sel;

    // Only encoder-bank writes with tap 0..9 land here
    assign enc_sel  = wt_wr && (wt.addr.enc.bank == 1'b0)
                      && (wt.addr.enc.tap <= 4'(vae_net_pkg::ENC_BIAS_TAP));
    assign bias_sel = (wt.addr.enc.tap == 4'(vae_net_pkg::ENC_BIAS_TAP));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int l = 0; l < vae_net_pkg::N_LAT; l++) begin
                for (int p = 0; p < vae_net_pkg::N_PIX; p++) begin
                    enc_w[l][p] <= fixed_point_pkg::W_INIT;
                end
                enc_b[l] <= fixed_point_pkg::B_INIT;
            end
        end else if (enc_sel) begin
            if (bias_sel) begin
                enc_b[wt.addr.enc.latent] <= wt.data;
            end else begin
                enc_w[wt.addr.enc.latent][wt.addr.enc.tap] <= wt.data;
            end
        end
    end

    // Binary pixels, so each product is the weight itself or zero
    always_comb begin : mean_calc
        fixed_point_pkg::q16_t acc [vae_net_pkg::N_LAT];
        for (int l = 0; l < vae_net_pkg::N_LAT; l++) begin
            acc[l] = enc_b[l];
            for (int p = 0; p < vae_net_pkg::N_PIX; p++) begin
                if (in_pixels[p]) begin
                    acc[l] = acc[l] + enc_w[l][p];
                end
            end
        end
        latent.mean0 = fixed_point_pkg::q_relu(acc[0]);
        latent.mean1 = fixed_point_pkg::q_relu(acc[1]);
    end

    assign push = in_valid;

endmodule

`default_nettype wire

/* src/vae_inference_top.sv */
// VAE inference top, encoder feeding a latent queue drained by the decoder
`timescale 1ns/1ps
`default_nettype none

module vae_inference_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  logic [vae_net_pkg::N_PIX-1:0] in_pixels,
    output logic                          in_full,
    input  logic                          wt_wr,
    input  vae_net_pkg::wt_write_t        wt,
    output logic                          out_valid,
    output vae_net_pkg::pixel_out_t       out_pixel
);

    logic                 lat_push;
    vae_net_pkg::latent_t lat_in;
    logic                 lat_full;
    logic                 lat_empty;
    vae_net_pkg::latent_t lat_head;
    logic                 lat_pop;

    vae_encoder u_encoder (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_pixels (in_pixels),
        .wt_wr     (wt_wr),
        .wt        (wt),
        .push      (lat_push),
        .latent    (lat_in)
    );

    latent_fifo u_latent_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (lat_push),
        .push_data (lat_in),
        .pop       (lat_pop),
        .full      (lat_full),
        .empty     (lat_empty),
        .head      (lat_head)
    );

    vae_decoder u_decoder (
        .clk       (clk),
        .arst_n    (arst_n),
        .empty     (lat_empty),
        .head      (lat_head),
        .pop       (lat_pop),
        .wt_wr     (wt_wr),
        .wt        (wt),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

    // Strobes while the queue is full are dropped
    assign in_full = lat_full;

endmodule

`default_nettype wire

/* src/vae_net_pkg.sv */
// Network sizes, weight address layouts and the data structs between blocks
`default_nettype none

package vae_net_pkg;

    localparam int N_PIX          = 9;
    localparam int N_LAT          = 2;
    localparam int LAT_FIFO_DEPTH = 4;

    // Tap that addresses the bias instead of a weight
    localparam int ENC_BIAS_TAP = 9;
    localparam int DEC_BIAS_TAP = 2;

    typedef logic [3:0] pixel_idx_t;

    // Encoder bank: bank bit 0, one pad bit, latent select, pixel tap
    typedef struct packed {
        logic       bank;
        logic       pad;
        logic       latent;
        logic [3:0] tap;
    } enc_addr_t;

    // Decoder bank: bank bit 1, output pixel, latent tap
    typedef struct packed {
        logic       bank;
        logic [3:0] out_idx;
        logic [1:0] tap;
    } dec_addr_t;

    // Same 7-bit word, read through whichever layout the bank bit picks
    typedef union packed {
        enc_addr_t enc;
        dec_addr_t dec;
    } wt_addr_u;

    typedef struct packed {
        wt_addr_u              addr;
        fixed_point_pkg::q16_t data;
    } wt_write_t;

    typedef struct packed {
        fixed_point_pkg::q16_t mean0;
        fixed_point_pkg::q16_t mean1;
    } latent_t;

    typedef struct packed {
        pixel_idx_t            index;
        fixed_point_pkg::q16_t value;
    } pixel_out_t;

endpackage

`default_nettype wire

/* vae_inference_top.f */
src/fixed_point_pkg.sv
src/vae_net_pkg.sv
src/vae_encoder.sv
src/latent_fifo.sv
src/vae_decoder.sv
src/vae_inference_top.sv
bench/vae_inference_properties.sv
bench/vae_inference_tb.sv
